/* common/memStage_config.svh */
`ifndef MEMSTAGE_CONFIG_SVH
`define MEMSTAGE_CONFIG_SVH

`default_nettype none

// Data word width, lanes stay 8 and 16 bits at 64
`define MEM_DATA_WIDTH 32

// Word-address bits of the data RAM
`define MEM_ADDR_BITS 8

`default_nettype wire

`endif

/* common/memStage_pkg.sv */
`include "memStage_config.svh"

`default_nettype none

package memStage_pkg;

    // Load and store width, funct3 encoding
    typedef enum logic [2:0] {
        MEM_OP_B  = 3'd0,
        MEM_OP_H  = 3'd1,
        MEM_OP_W  = 3'd2,
        MEM_OP_BU = 3'd4,
        MEM_OP_HU = 3'd5
    } memOpE;

    // Writeback result source, code 3 falls back to ALU
    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2
    } resultSrcE;

    localparam int unsigned MEM_LANES = `MEM_DATA_WIDTH / 8;

    // One data word, seen whole or as byte lanes
    typedef union packed {
        logic [`MEM_DATA_WIDTH-1:0]  word;
        logic [MEM_LANES-1:0][7:0]   lanes;
    } memWordU;

endpackage

`default_nettype wire

/* hw/dataRam.sv */
`include "memStage_config.svh"

`default_nettype none

module dataRam (
    input  logic                        clk_i,
    input  logic                        writeEn_i,
    input  logic [`MEM_ADDR_BITS-1:0]   wordAddr_i,
    input  memStage_pkg::memWordU       wdata_i,
    output memStage_pkg::memWordU       rdata_o
);

    localparam int unsigned DEPTH = 2 ** `MEM_ADDR_BITS;

    logic [`MEM_DATA_WIDTH-1:0] mem [DEPTH];

    // Asynchronous read
    assign rdata_o.word = mem[wordAddr_i];

    // Write on the rising edge, independent of pipeline stall
    always_ff @(posedge clk_i) begin
        if (writeEn_i) begin
            mem[wordAddr_i] <= wdata_i.word;
        end
    end

endmodule

`default_nettype wire

/* hw/loadStoreAlign.sv */
`include "memStage_config.svh"

`default_nettype none

module loadStoreAlign (
    input  memStage_pkg::memOpE             memOp_i,
    input  logic [1:0]                      byteOffset_i,
    input  logic [`MEM_DATA_WIDTH-1:0]      storeData_i,
    input  memStage_pkg::memWordU           ramRdata_i,
    output memStage_pkg::memWordU           ramWdata_o,
    output logic [`MEM_DATA_WIDTH-1:0]      loadData_o
);

    import memStage_pkg::*;

    localparam int unsigned W = `MEM_DATA_WIDTH;

    logic [1:0]  halfLo;
    logic [1:0]  halfHi;
    logic [7:0]  loadByte;
    logic [15:0] loadHalf;

    // Halfword lanes picked by offset bit 1, bit 0 ignored
    assign halfLo = {byteOffset_i[1], 1'b0};
    assign halfHi = {byteOffset_i[1], 1'b1};

    // ############################
    // Store merge
    // ############################

    always_comb begin
        ramWdata_o = ramRdata_i;
        case (memOp_i)
            MEM_OP_B, MEM_OP_BU: begin
                ramWdata_o.lanes[byteOffset_i] = storeData_i[7:0];
            end
            MEM_OP_H, MEM_OP_HU: begin
                ramWdata_o.lanes[halfLo] = storeData_i[7:0];
                ramWdata_o.lanes[halfHi] = storeData_i[15:8];
            end
            default: begin
                ramWdata_o.word = storeData_i;
            end
        endcase
    end

    // ############################
    // Load extract and extend
    // ############################

    assign loadByte = ramRdata_i.lanes[byteOffset_i];
    assign loadHalf = {ramRdata_i.lanes[halfHi], ramRdata_i.lanes[halfLo]};

    always_comb begin
        case (memOp_i)
            MEM_OP_B:  loadData_o = {{(W-8){loadByte[7]}}, loadByte};
            MEM_OP_BU: loadData_o = {{(W-8){1'b0}}, loadByte};
            MEM_OP_H:  loadData_o = {{(W-16){loadHalf[15]}}, loadHalf};
            MEM_OP_HU: loadData_o = {{(W-16){1'b0}}, loadHalf};
            // Word and unused codes return the whole word
            default:   loadData_o = ramRdata_i.word;
        endcase
    end

endmodule

`default_nettype wire

/* hw/memWbStage.sv */
`include "memStage_config.svh"

`default_nettype none

module memWbStage (
    input  logic                            clk_i,
    input  logic                            arstN_i,
    input  logic                            stall_i,
    input  logic                            regWrite_i,
    input  memStage_pkg::resultSrcE         resultSrc_i,
    input  logic [`MEM_DATA_WIDTH-1:0]      aluResult_i,
    input  logic [`MEM_DATA_WIDTH-1:0]      loadData_i,
    input  logic [`MEM_DATA_WIDTH-1:0]      pcPlus4_i,
    input  logic [4:0]                      rd_i,
    output logic                            regWrite_o,
    output logic [4:0]                      rd_o,
    output logic [`MEM_DATA_WIDTH-1:0]      result_o
);

    import memStage_pkg::*;

    logic                           regWriteQ;
    resultSrcE                      resultSrcQ;
    logic [`MEM_DATA_WIDTH-1:0]     aluResultQ;
    logic [`MEM_DATA_WIDTH-1:0]     loadDataQ;
    logic [`MEM_DATA_WIDTH-1:0]     pcPlus4Q;
    logic [4:0]                     rdQ;

    // ############################
    // Pipeline register
    // ############################

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            regWriteQ  <= 1'b0;
            resultSrcQ <= RES_ALU;
            aluResultQ <= '0;
            loadDataQ  <= '0;
            pcPlus4Q   <= '0;
            rdQ        <= '0;
        end else if (!stall_i) begin
            regWriteQ  <= regWrite_i;
            resultSrcQ <= resultSrc_i;
            aluResultQ <= aluResult_i;
            loadDataQ  <= loadData_i;
            pcPlus4Q   <= pcPlus4_i;
            rdQ        <= rd_i;
        end
    end

    // ############################
    // Result select
    // ############################

    always_comb begin
        case (resultSrcQ)
            RES_MEM: result_o = loadDataQ;
            RES_PC4: result_o = pcPlus4Q;
            default: result_o = aluResultQ;
        endcase
    end

    assign regWrite_o = regWriteQ;
    assign rd_o       = rdQ;

endmodule

`default_nettype wire

/* hw/memWriteTop.sv */
`include "memStage_config.svh"

`default_nettype none

module memWriteTop (
    input  logic                            clk_i,
    input  logic                            arstN_i,
    input  logic                            stall_i,

    input  logic                            regWriteM_i,
    input  logic                            memWriteM_i,
    input  memStage_pkg::resultSrcE         resultSrcM_i,
    input  memStage_pkg::memOpE             memOpM_i,
    input  logic [`MEM_DATA_WIDTH-1:0]      aluResultM_i,
    input  logic [`MEM_DATA_WIDTH-1:0]      writeDataM_i,
    input  logic [`MEM_DATA_WIDTH-1:0]      pcPlus4M_i,
    input  logic [4:0]                      rdM_i,

    // Back to execute for forwarding
    output logic [`MEM_DATA_WIDTH-1:0]      readDataM_o,

    output logic                            regWriteW_o,
    output logic [4:0]                      rdW_o,
    output logic [`MEM_DATA_WIDTH-1:0]      resultW_o
);

    import memStage_pkg::*;

    logic [`MEM_ADDR_BITS-1:0]      wordAddr;
    logic [1:0]                     byteOffset;
    memWordU                        ramRdata;
    memWordU                        ramWdata;
    logic [`MEM_DATA_WIDTH-1:0]     loadData;

    // Word address sits above the byte offset
    assign wordAddr   = aluResultM_i[`MEM_ADDR_BITS+1:2];
    assign byteOffset = aluResultM_i[1:0];

    // ############################
    // Memory access
    // ############################

    dataRam u_dataRam (
        .clk_i      (clk_i),
        .writeEn_i  (memWriteM_i),
        .wordAddr_i (wordAddr),
        .wdata_i    (ramWdata),
        .rdata_o    (ramRdata)
    );

    loadStoreAlign u_align (
        .memOp_i      (memOpM_i),
        .byteOffset_i (byteOffset),
        .storeData_i  (writeDataM_i),
        .ramRdata_i   (ramRdata),
        .ramWdata_o   (ramWdata),
        .loadData_o   (loadData)
    );

    assign readDataM_o = loadData;

    // ############################
    // Writeback
    // ############################

    memWbStage u_memWb (
        .clk_i       (clk_i),
        .arstN_i     (arstN_i),
        .stall_i     (stall_i),
        .regWrite_i  (regWriteM_i),
        .resultSrc_i (resultSrcM_i),
        .aluResult_i (aluResultM_i),
        .loadData_i  (loadData),
        .pcPlus4_i   (pcPlus4M_i),
        .rd_i        (rdM_i),
        .regWrite_o  (regWriteW_o),
        .rd_o        (rdW_o),
        .result_o    (resultW_o)
    );

endmodule

`default_nettype wire

/* bench/memWrite_props.sv */
`include "memStage_config.svh"

`default_nettype none

module memWrite_props (
    input  logic                            clk_i,
    input  logic                            arstN_i,
    input  logic                            stall_i,
    input  logic                            regWrite_i,
    input  logic [4:0]                      rd_i,
    input  logic [`MEM_DATA_WIDTH-1:0]      result_i,
    input  logic [`MEM_DATA_WIDTH-1:0]      pcPlus4_i,
    input  memStage_pkg::resultSrcE         resultSrc_i
);
    timeunit 1ns;
    timeprecision 1ps;

    import memStage_pkg::*;

    // Read by the testbench at the end of the run
    int unsigned failCount = 0;

    // No write enable right after reset release
    resetReleaseQuiet: assert property (@(posedge clk_i) $rose(arstN_i) |-> !regWrite_i)
        else begin
            $error("regWrite_o high in the cycle after reset release");
            failCount++;
        end

    // A stalled cycle leaves the W outputs untouched
    stallHoldsOutputs: assert property (@(posedge clk_i) disable iff (!arstN_i)
        stall_i |=> ($stable(regWrite_i) && $stable(rd_i) && $stable(result_i)))
        else begin
            $error("W outputs changed in the cycle after a stall");
            failCount++;
        end

    // PC plus 4 taken on an unstalled edge comes out as the result
    pcPlus4Selected: assert property (@(posedge clk_i) disable iff (!arstN_i)
        (!stall_i && resultSrc_i == RES_PC4) |=> (result_i == $past(pcPlus4_i)))
        else begin
            $error("result_o differs from captured pcPlus4 with source PC plus 4");
            failCount++;
        end

endmodule

bind memWbStage memWrite_props u_props (
    .clk_i       (clk_i),
    .arstN_i     (arstN_i),
    .stall_i     (stall_i),
    .regWrite_i  (regWrite_o),
    .rd_i        (rd_o),
    .result_i    (result_o),
    .pcPlus4_i   (pcPlus4_i),
    .resultSrc_i (resultSrc_i)
);

`default_nettype wire

/* bench/memWriteChecker.sv */
`include "memStage_config.svh"

`default_nettype none

module memWriteChecker (
    input  logic                            clk_i,
    input  logic                            arstN_i,
    input  logic                            stall_i,
    input  logic                            regWriteM_i,
    input  logic                            memWriteM_i,
    input  memStage_pkg::resultSrcE         resultSrcM_i,
    input  memStage_pkg::memOpE             memOpM_i,
    input  logic [`MEM_DATA_WIDTH-1:0]      aluResultM_i,
    input  logic [`MEM_DATA_WIDTH-1:0]      writeDataM_i,
    input  logic [`MEM_DATA_WIDTH-1:0]      pcPlus4M_i,
    input  logic [4:0]                      rdM_i,
    input  logic [`MEM_DATA_WIDTH-1:0]      readDataM_i,
    input  logic                            regWriteW_i,
    input  logic [4:0]                      rdW_i,
    input  logic [`MEM_DATA_WIDTH-1:0]      resultW_i,
    input  int                              testId_i,
    input  logic                            testDone_i,
    output int                              errors_o
);
    timeunit 1ns;
    timeprecision 1ps;

    import memStage_pkg::*;

    localparam int W     = `MEM_DATA_WIDTH;
    localparam int DEPTH = 2 ** `MEM_ADDR_BITS;

    logic [W-1:0]               modelMem [DEPTH];
    logic [DEPTH-1:0]           modelValid = '0;
    logic                       mRegWrite;
    logic [4:0]                 mRd;
    logic [W-1:0]               mResult;
    logic [`MEM_ADDR_BITS-1:0]  wordAddr;
    logic [1:0]                 byteOff;
    logic [W-1:0]               expLoad;
    int                         testErrors = 0;
    int                         totalErrors = 0;

    // ##############################
    // Reference rules
    // ##############################

    function automatic logic [W-1:0] mergeStore(input logic [W-1:0] oldWord,
                                                input logic [W-1:0] data,
                                                input memOpE op,
                                                input logic [1:0] off);
        logic [W-1:0] mask;
        logic [W-1:0] lanes;
        int unsigned  shift;
        shift = 0;
        case (op)
            MEM_OP_B, MEM_OP_BU: begin
                shift = 32'(off) * 8;
                mask  = W'(8'hFF) << shift;
                lanes = W'(data[7:0]) << shift;
            end
            MEM_OP_H, MEM_OP_HU: begin
                shift = off[1] ? 16 : 0;
                mask  = W'(16'hFFFF) << shift;
                lanes = W'(data[15:0]) << shift;
            end
            default: begin
                mask  = '1;
                lanes = data;
            end
        endcase
        return (oldWord & ~mask) | lanes;
    endfunction

    function automatic logic [W-1:0] extractLoad(input logic [W-1:0] word,
                                                 input memOpE op,
                                                 input logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(word >> (32'(off) * 8));
        h = 16'(word >> (off[1] ? 16 : 0));
        case (op)
            MEM_OP_B:  return {{(W-8){b[7]}}, b};
            MEM_OP_BU: return {{(W-8){1'b0}}, b};
            MEM_OP_H:  return {{(W-16){h[15]}}, h};
            MEM_OP_HU: return {{(W-16){1'b0}}, h};
            default:   return word;
        endcase
    endfunction

    function automatic logic [W-1:0] selectResult(input resultSrcE src,
                                                  input logic [W-1:0] alu,
                                                  input logic [W-1:0] load,
                                                  input logic [W-1:0] pc4);
        case (src)
            RES_MEM: return load;
            RES_PC4: return pc4;
            default: return alu;
        endcase
    endfunction

    function automatic string testName(input int id);
        case (id)
            1: return "word round trip";
            2: return "byte and halfword stores";
            3: return "load extension";
            4: return "result selection";
            5: return "stall";
            6: return "mid-run reset";
            default: return "unnamed";
        endcase
    endfunction

    task automatic compareValue(input string sig, input logic [W-1:0] exp,
                                input logic [W-1:0] act);
        if (exp !== act) begin
            $display("ERROR at %0t: %s expected %h actual %h", $time, sig, exp, act);
            testErrors++;
            totalErrors++;
        end
    endtask

    // ##############################
    // Models
    // ##############################

    assign wordAddr = aluResultM_i[`MEM_ADDR_BITS+1:2];
    assign byteOff  = aluResultM_i[1:0];
    assign expLoad  = extractLoad(modelMem[wordAddr], memOpM_i, byteOff);
    assign errors_o = totalErrors;

    // Stores land whatever the stall
    always @(posedge clk_i) begin
        if (memWriteM_i) begin
            modelMem[wordAddr]   <= mergeStore(modelMem[wordAddr], writeDataM_i,
                                               memOpM_i, byteOff);
            modelValid[wordAddr] <= 1'b1;
        end
    end

    always @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            mRegWrite <= 1'b0;
            mRd       <= '0;
            mResult   <= '0;
        end else if (!stall_i) begin
            mRegWrite <= regWriteM_i;
            mRd       <= rdM_i;
            mResult   <= selectResult(resultSrcM_i, aluResultM_i, expLoad, pcPlus4M_i);
        end
    end

    always @(negedge clk_i) begin
        compareValue("regWriteW_o", W'(mRegWrite), W'(regWriteW_i));
        compareValue("rdW_o", W'(mRd), W'(rdW_i));
        compareValue("resultW_o", mResult, resultW_i);
        // Words not yet written have no expected value
        if (modelValid[wordAddr]) begin
            compareValue("readDataM_o", expLoad, readDataM_i);
        end
        if (testDone_i) begin
            $display("Test %0d (%s) done: %0d errors", testId_i, testName(testId_i),
                     testErrors);
            testErrors = 0;
        end
    end

endmodule

`default_nettype wire

/* bench/memWriteTb.sv */
`include "memStage_config.svh"

`default_nettype none

module memWriteTb;
    timeunit 1ns;
    timeprecision 1ps;

    import memStage_pkg::*;

    localparam int W           = `MEM_DATA_WIDTH;
    localparam int DEPTH       = 2 ** `MEM_ADDR_BITS;
    localparam int NUM_TESTS   = 6;
    localparam int TEST_CYCLES = 200;
    // Tests at their longest, the fill sweep, resets and some slack
    localparam int MAX_CYCLES  = NUM_TESTS * TEST_CYCLES + DEPTH + 500;

    logic           clk = 1'b0;
    logic           arstN;
    logic           stall;
    logic           regWriteM;
    logic           memWriteM;
    resultSrcE      resultSrcM;
    memOpE          memOpM;
    logic [W-1:0]   aluResultM;
    logic [W-1:0]   writeDataM;
    logic [W-1:0]   pcPlus4M;
    logic [4:0]     rdM;
    logic [W-1:0]   readDataM;
    logic           regWriteW;
    logic [4:0]     rdW;
    logic [W-1:0]   resultW;

    int             testId;
    logic           testDone;
    int             chkErrors;
    int             errorCount;
    int             cycleCount = 0;

    always #10 clk = ~clk;

    memWriteTop u_dut (
        .clk_i        (clk),
        .arstN_i      (arstN),
        .stall_i      (stall),
        .regWriteM_i  (regWriteM),
        .memWriteM_i  (memWriteM),
        .resultSrcM_i (resultSrcM),
        .memOpM_i     (memOpM),
        .aluResultM_i (aluResultM),
        .writeDataM_i (writeDataM),
        .pcPlus4M_i   (pcPlus4M),
        .rdM_i        (rdM),
        .readDataM_o  (readDataM),
        .regWriteW_o  (regWriteW),
        .rdW_o        (rdW),
        .resultW_o    (resultW)
    );

    memWriteChecker u_chk (
        .clk_i        (clk),
        .arstN_i      (arstN),
        .stall_i      (stall),
        .regWriteM_i  (regWriteM),
        .memWriteM_i  (memWriteM),
        .resultSrcM_i (resultSrcM),
        .memOpM_i     (memOpM),
        .aluResultM_i (aluResultM),
        .writeDataM_i (writeDataM),
        .pcPlus4M_i   (pcPlus4M),
        .rdM_i        (rdM),
        .readDataM_i  (readDataM),
        .regWriteW_i  (regWriteW),
        .rdW_i        (rdW),
        .resultW_i    (resultW),
        .testId_i     (testId),
        .testDone_i   (testDone),
        .errors_o     (chkErrors)
    );

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // ##############################
    // Driving helpers
    // ##############################

    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic setIdle();
        stall      = 1'b0;
        regWriteM  = 1'b0;
        memWriteM  = 1'b0;
        resultSrcM = RES_ALU;
        memOpM     = MEM_OP_W;
        aluResultM = '0;
        writeDataM = '0;
        pcPlus4M   = '0;
        rdM        = '0;
    endtask

    function automatic logic [W-1:0] byteAddr(input int unsigned idx, input logic [1:0] off);
        return (W'(idx) << 2) | W'(off);
    endfunction

    function automatic logic [W-1:0] randAddr();
        return byteAddr($urandom_range(0, DEPTH - 1), 2'($urandom));
    endfunction

    function automatic memOpE randPartialOp();
        case ($urandom_range(0, 3))
            0:       return MEM_OP_B;
            1:       return MEM_OP_H;
            2:       return MEM_OP_BU;
            default: return MEM_OP_HU;
        endcase
    endfunction

    function automatic memOpE randOp();
        if ($urandom_range(0, 4) == 0) begin
            return MEM_OP_W;
        end
        return randPartialOp();
    endfunction

    // One instruction, side fields random, then one clock
    task automatic issueOp(input logic isStore, input memOpE op, input logic [W-1:0] addr,
                           input logic [W-1:0] data, input logic hold);
        memWriteM  = isStore;
        memOpM     = op;
        aluResultM = addr;
        writeDataM = data;
        stall      = hold;
        regWriteM  = 1'($urandom);
        resultSrcM = resultSrcE'(2'($urandom));
        rdM        = 5'($urandom);
        pcPlus4M   = W'($urandom);
        nextCycle();
    endtask

    task automatic issueRandom(input logic hold);
        issueOp(1'($urandom_range(0, 2) == 0), randOp(), randAddr(), W'($urandom), hold);
    endtask

    task automatic finishTest();
        setIdle();
        testDone = 1'b1;
        nextCycle();
        testDone = 1'b0;
    endtask

    // ##############################
    // Tests
    // ##############################

    task automatic fillRam();
        for (int i = 0; i < DEPTH; i++) begin
            issueOp(1'b1, MEM_OP_W, byteAddr(i, 2'b00),
                    {(W/32){32'(i) * 32'h9E37_79B9 + 32'h0F1E_2D3C}}, 1'b0);
        end
    endtask

    task automatic wordRoundTrip();
        logic [W-1:0] addr;
        for (int i = 0; i < 40; i++) begin
            addr = randAddr();
            issueOp(1'b1, MEM_OP_W, addr, W'($urandom), 1'b0);
            issueOp(1'b0, MEM_OP_W, addr, '0, 1'b0);
        end
    endtask

    task automatic partialStores();
        logic [W-1:0] addr;
        for (int i = 0; i < 40; i++) begin
            addr = randAddr();
            issueOp(1'b1, randPartialOp(), addr, W'($urandom), 1'b0);
            issueOp(1'b0, MEM_OP_W, addr, '0, 1'b0);
        end
    endtask

    task automatic loadExtension();
        int unsigned idx;
        for (int i = 0; i < 25; i++) begin
            idx = $urandom_range(0, DEPTH - 1);
            issueOp(1'b1, MEM_OP_W, byteAddr(idx, 2'b00), W'($urandom), 1'b0);
            repeat (4) begin
                issueOp(1'b0, randPartialOp(), byteAddr(idx, 2'($urandom)), '0, 1'b0);
            end
        end
    endtask

    task automatic resultSelection();
        repeat (100) issueRandom(1'b0);
    endtask

    task automatic stallHold();
        logic [W-1:0] addr;
        for (int i = 0; i < 50; i++) begin
            addr = randAddr();
            issueOp(1'b1, randOp(), addr, W'($urandom), 1'($urandom_range(0, 2) == 0));
            issueOp(1'b0, randOp(), addr, '0, 1'($urandom_range(0, 2) == 0));
        end
    endtask

    task automatic midRunReset();
        repeat (10) issueRandom(1'b0);
        arstN = 1'b0;
        repeat (3) issueOp(1'b0, randOp(), randAddr(), '0, 1'b0);
        arstN = 1'b1;
        // W outputs stay cleared while stalled
        repeat (4) issueRandom(1'b1);
        repeat (20) issueRandom(1'b0);
    endtask

    initial begin
        void'($urandom(32'h950b8faf));
        testId   = 0;
        testDone = 1'b0;
        arstN    = 1'b0;
        setIdle();
        repeat (3) @(posedge clk);
        #2;
        arstN = 1'b1;

        fillRam();
        testId = 1;
        wordRoundTrip();
        finishTest();
        testId = 2;
        partialStores();
        finishTest();
        testId = 3;
        loadExtension();
        finishTest();
        testId = 4;
        resultSelection();
        finishTest();
        testId = 5;
        stallHold();
        finishTest();
        testId = 6;
        midRunReset();
        finishTest();

        errorCount = chkErrors + int'(u_dut.u_memWb.u_props.failCount);
        $display("Tests run: %0d, errors: %0d", NUM_TESTS, errorCount);
        if (errorCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+common
common/memStage_pkg.sv
hw/dataRam.sv
hw/loadStoreAlign.sv
hw/memWbStage.sv
hw/memWriteTop.sv
bench/memWrite_props.sv
bench/memWriteChecker.sv
bench/memWriteTb.sv

/* Makefile */
# Verilator build and run of the memory and writeback back end

VERILATOR ?= verilator
TOP       ?= memWriteTb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= === PASS ===

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(SIM) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
